// ==== dbg_mam_bb_top.f ====
mam_pkg.sv
mem_pkg.sv
mam_cmd_decoder.sv
mam_req_fifo.sv
mam_bb_if.sv
mam_bram.sv
dbg_mam_bb_top.sv
tb_dbg_mam_bb_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module tb_dbg_mam_bb_top \
  -f dbg_mam_bb_top.f \
  -o sim_tb_dbg_mam_bb_top

# Exit status is nonzero when the testbench stops with $fatal
./obj_dir/sim_tb_dbg_mam_bb_top

// ==== tb_dbg_mam_bb_top.sv ====
`default_nettype none

module tb_dbg_mam_bb_top;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_CMDS = 18;

  typedef struct packed {
    logic        we;
    logic        burst;
    logic [1:0]  strb;
    logic [11:0] beats;
    logic [31:0] addr;
    logic [15:0] seed;     // Mixed into random write data
  } cmd_t;

  logic        clk_i       = 1'b0;
  logic        rst_i       = 1'b1;
  logic        dbg_valid_i = 1'b0;
  logic [15:0] dbg_word_i  = 16'h0000;
  logic        dbg_ready_o;
  logic        rd_valid_o;
  logic [15:0] rd_data_o;
  logic        rd_ready_i  = 1'b0;

  logic [15:0] mem_model [256];  // Expected RAM contents
  logic [15:0] word_q [$];       // Debug words still to send
  logic [15:0] exp_data_q [$];   // Read beats still expected
  string       exp_name_q [$];   // Command of each expected beat

  ////////////////////////////////////////////////////////////////////////////
  // Command table
  ////////////////////////////////////////////////////////////////////////////

  cmd_t cmd_tbl [NUM_CMDS] = '{
    //  we    burst strb   beats    addr           seed
    '{1'b1, 1'b1, 2'b11, 12'd256, 32'h0000_0000, 16'h3c5a},  // Preload every word
    '{1'b1, 1'b1, 2'b11, 12'd8,   32'h0000_0010, 16'h1234},
    '{1'b0, 1'b1, 2'b11, 12'd8,   32'h0000_0010, 16'h0000},
    '{1'b1, 1'b0, 2'b01, 12'd1,   32'h0000_0020, 16'h00ff},  // Low byte only
    '{1'b0, 1'b0, 2'b11, 12'd1,   32'h0000_0020, 16'h0000},
    '{1'b1, 1'b0, 2'b10, 12'd5,   32'h0000_0021, 16'hff00},  // Beats ignored on single
    '{1'b0, 1'b0, 2'b11, 12'd1,   32'h0000_0021, 16'h0000},
    '{1'b1, 1'b1, 2'b01, 12'd8,   32'h0000_00fc, 16'h5a5a},  // Burst forces full strobe
    '{1'b0, 1'b1, 2'b11, 12'd8,   32'h0000_00fc, 16'h0000},
    '{1'b0, 1'b0, 2'b11, 12'd1,   32'h0000_0040, 16'h0000},
    '{1'b0, 1'b1, 2'b11, 12'd3,   32'h0000_0050, 16'h0000},
    '{1'b0, 1'b1, 2'b11, 12'd4,   32'h0001_0060, 16'h0000},  // Upper bits dropped
    '{1'b0, 1'b1, 2'b11, 12'd2,   32'h0000_00ff, 16'h0000},  // Queue now full
    '{1'b1, 1'b0, 2'b11, 12'd1,   32'h0000_0041, 16'h7777},  // Waits on a full queue
    '{1'b0, 1'b0, 2'b11, 12'd1,   32'h0000_0041, 16'h0000},
    '{1'b1, 1'b1, 2'b11, 12'd0,   32'h0000_0030, 16'h4321},  // Zero length burst
    '{1'b0, 1'b1, 2'b11, 12'd0,   32'h0000_0030, 16'h0000},
    '{1'b0, 1'b1, 2'b11, 12'd2,   32'h0000_0030, 16'h0000}   // Neighbour untouched
  };

  string name_tbl [NUM_CMDS] = '{
    "fill", "burst_wr8", "burst_rd8", "byte_wr_lo", "byte_rd_lo", "byte_wr_hi",
    "byte_rd_hi", "wrap_wr", "wrap_rd", "b2b_rd0", "b2b_rd1", "b2b_rd2",
    "b2b_rd3", "b2b_wr4", "b2b_rd5", "zero_wr", "zero_rd", "zero_chk"
  };

  dbg_mam_bb_top i_dut (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .dbg_valid_i (dbg_valid_i),
    .dbg_word_i  (dbg_word_i),
    .dbg_ready_o (dbg_ready_o),
    .rd_valid_o  (rd_valid_o),
    .rd_data_o   (rd_data_o),
    .rd_ready_i  (rd_ready_i)
  );

  always #50 clk_i = ~clk_i;  // 100 ns period

  // Single and zero length commands move one word
  function automatic int unsigned eff_beats(input cmd_t c);
    if (!c.burst || c.beats == 12'd0) return 1;
    return 32'(c.beats);
  endfunction

  task automatic check_value(input string test_name, input logic [15:0] expected,
                             input logic [15:0] actual);
    if (actual !== expected) begin
      $display("ERROR %s: expected %h, actual %h", test_name, expected, actual);
      $display("test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // Word stream and expected reads, model updated in command order
  task automatic build_stream();
    cmd_t        c;
    int unsigned n;
    logic [15:0] data;
    logic [7:0]  a;
    logic [1:0]  strb;
    for (int i = 0; i < NUM_CMDS; i++) begin
      c    = cmd_tbl[i];
      n    = eff_beats(c);
      strb = c.burst ? 2'b11 : c.strb;                     // Bursts write whole words
      word_q.push_back({c.we, c.burst, c.strb, c.beats});  // Header
      word_q.push_back(c.addr[31:16]);
      word_q.push_back(c.addr[15:0]);
      for (int unsigned j = 0; j < n; j++) begin
        a = 8'(c.addr + j);                                // 256 word wrap
        if (c.we) begin
          data = 16'($urandom) ^ c.seed;
          word_q.push_back(data);
          for (int b = 0; b < 2; b++) begin
            if (strb[b]) mem_model[a][8*b +: 8] = data[8*b +: 8];
          end
        end else begin
          exp_data_q.push_back(mem_model[a]);
          exp_name_q.push_back(name_tbl[i]);
        end
      end
    end
  endtask

  // Hold one word on the bus until the DUT takes it
  task automatic send_word(input logic [15:0] word);
    logic taken;
    taken = 1'b0;
    dbg_valid_i <= 1'b1;
    dbg_word_i  <= word;
    while (!taken) begin
      @(negedge clk_i);
      taken = dbg_ready_o;  // Transfer on the coming edge
      @(posedge clk_i);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h05538c02));
    build_stream();
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    check_value("reset", 16'd0, 16'(rd_valid_o));
    check_value("reset", 16'd0, 16'(dbg_ready_o));  // Held off one cycle
    @(negedge clk_i);
    check_value("reset", 16'd1, 16'(dbg_ready_o));
    @(posedge clk_i);
    while (word_q.size() != 0) begin
      send_word(word_q.pop_front());              // No gaps between commands
    end
    dbg_valid_i <= 1'b0;
    while (exp_data_q.size() != 0) @(posedge clk_i);
    repeat (20) @(posedge clk_i);                 // Room for a stray beat to show
    $display("test passed");
    $finish;
  end

  // Read side with random back-pressure
  initial begin
    logic        held;
    logic [15:0] held_data;
    logic [15:0] exp;
    string       name;
    held      = 1'b0;
    held_data = 16'h0000;
    wait (rst_i == 1'b0);
    forever begin
      @(posedge clk_i);
      rd_ready_i <= 1'($urandom % 2);
      @(negedge clk_i);
      if (rd_valid_o && exp_data_q.size() == 0) begin
        $display("Unexpected read beat %h while no read was pending", rd_data_o);
        $display("test failed");
        $fatal(1, "extra read beat");
      end
      if (held) begin                             // Must stay put until taken
        check_value(exp_name_q[0], 16'd1, 16'(rd_valid_o));
        check_value(exp_name_q[0], held_data, rd_data_o);
      end
      held = 1'b0;
      if (rd_valid_o) begin
        if (rd_ready_i) begin
          name = exp_name_q.pop_front();
          exp  = exp_data_q.pop_front();
          check_value(name, exp, rd_data_o);
        end else begin
          held      = 1'b1;
          held_data = rd_data_o;
        end
      end
    end
  end

  // Watchdog scaled to the table length
  initial begin
    int unsigned total_beats;
    int unsigned limit;
    total_beats = 0;
    for (int i = 0; i < NUM_CMDS; i++) total_beats += eff_beats(cmd_tbl[i]);
    limit = total_beats * 20 + 500;
    repeat (limit) @(posedge clk_i);
    $display("Timeout: the run did not finish within %0d cycles", limit);
    $display("test failed");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// ==== dbg_mam_bb_top.sv ====
`default_nettype none

module dbg_mam_bb_top
  import mam_pkg::*;
  import mem_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  dbg_valid_i,
  input  logic [DATA_WIDTH-1:0] dbg_word_i,
  output logic                  dbg_ready_o,
  output logic                  rd_valid_o,
  output logic [DATA_WIDTH-1:0] rd_data_o,
  input  logic                  rd_ready_i
);

  logic                  req_valid;   // Decoder to queue
  mam_req_t              req;
  logic                  req_full;
  logic                  q_valid;     // Queue head to interface
  mam_req_t              q_req;
  logic                  q_pop;
  logic                  wr_valid;    // Write data, bypasses queue
  logic [DATA_WIDTH-1:0] wr_data;
  logic                  wr_ready;
  mem_req_t              mem_req;     // Interface to RAM
  logic [DATA_WIDTH-1:0] mem_rdata;

  mam_cmd_decoder i_decoder (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .dbg_valid_i (dbg_valid_i),
    .dbg_word_i  (dbg_word_i),
    .dbg_ready_o (dbg_ready_o),
    .req_valid_o (req_valid),
    .req_o       (req),
    .req_ready_i (~req_full),        // Room in queue
    .wr_valid_o  (wr_valid),
    .wr_data_o   (wr_data),
    .wr_ready_i  (wr_ready)
  );

  mam_req_fifo i_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (req_valid),
    .req_i   (req),
    .full_o  (req_full),
    .pop_i   (q_pop),
    .req_o   (q_req),
    .valid_o (q_valid)
  );

  mam_bb_if i_bb_if (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .q_valid_i   (q_valid),
    .q_req_i     (q_req),
    .q_pop_o     (q_pop),
    .wr_valid_i  (wr_valid),
    .wr_data_i   (wr_data),
    .wr_ready_o  (wr_ready),
    .rd_valid_o  (rd_valid_o),
    .rd_data_o   (rd_data_o),
    .rd_ready_i  (rd_ready_i),
    .mem_o       (mem_req),
    .mem_rdata_i (mem_rdata)
  );

  mam_bram i_bram (
    .clk_i   (clk_i),
    .mem_i   (mem_req),
    .rdata_o (mem_rdata)
  );

endmodule

`default_nettype wire

// ==== mam_bram.sv ====
`default_nettype none

module mam_bram
  import mam_pkg::*;
  import mem_pkg::*;
(
  input  logic                  clk_i,
  input  mem_req_t              mem_i,
  output logic [DATA_WIDTH-1:0] rdata_o
);

  logic [DATA_WIDTH-1:0] ram_q [MEM_DEPTH];  // Word array

  always_ff @(posedge clk_i) begin
    if (mem_i.en) begin
      if (mem_i.we) begin
        for (int b = 0; b < STRB_WIDTH; b++) begin
          if (mem_i.be[b]) begin
            ram_q[mem_i.addr][b*8 +: 8] <= mem_i.wdata[b*8 +: 8];  // Byte lane write
          end
        end
      end
      rdata_o <= ram_q[mem_i.addr];  // Registered read, old data on write
    end
  end

endmodule

`default_nettype wire

// ==== mam_bb_if.sv ====
`default_nettype none

module mam_bb_if
  import mam_pkg::*;
  import mem_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  q_valid_i,
  input  mam_req_t              q_req_i,
  output logic                  q_pop_o,
  input  logic                  wr_valid_i,
  input  logic [DATA_WIDTH-1:0] wr_data_i,
  output logic                  wr_ready_o,
  output logic                  rd_valid_o,
  output logic [DATA_WIDTH-1:0] rd_data_o,
  input  logic                  rd_ready_i,
  output mem_req_t              mem_o,
  input  logic [DATA_WIDTH-1:0] mem_rdata_i
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WRITE_WAIT,    // Waiting for a data word
    ST_WRITE,         // RAM write strobe
    ST_READ,          // RAM read strobe
    ST_READ_CAPTURE,  // RAM output valid, register it
    ST_READ_WAIT      // Offer beat downstream
  } state_e;

  state_e                 state_q, state_d;
  logic [ADDR_WIDTH-1:0]  addr_q, addr_d;    // Current word address
  logic [BEATS_WIDTH-1:0] beats_q, beats_d;  // Beats left to issue
  logic [STRB_WIDTH-1:0]  strb_q, strb_d;
  logic [DATA_WIDTH-1:0]  din_q, din_d;      // Write data of current beat
  logic [DATA_WIDTH-1:0]  rdata_q, rdata_d;  // Captured read beat

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
    addr_q  <= addr_d;
    beats_q <= beats_d;
    strb_q  <= strb_d;
    din_q   <= din_d;
    rdata_q <= rdata_d;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Next state and outputs
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    addr_d  = addr_q;
    beats_d = beats_q;
    strb_d  = strb_q;
    din_d   = din_q;
    rdata_d = rdata_q;

    q_pop_o    = 1'b0;
    wr_ready_o = 1'b0;
    rd_valid_o = 1'b0;
    rd_data_o  = rdata_q;          // Held while waiting for ready

    mem_o.en    = 1'b0;
    mem_o.we    = 1'b0;
    mem_o.addr  = addr_q[MEM_AW-1:0];  // Upper bits dropped, wraps
    mem_o.wdata = din_q;
    mem_o.be    = strb_q;

    case (state_q)
      ST_IDLE: begin
        q_pop_o = q_valid_i;
        if (q_valid_i) begin
          addr_d  = q_req_i.addr;
          beats_d = q_req_i.beats;
          strb_d  = q_req_i.strb;
          state_d = q_req_i.we ? ST_WRITE_WAIT : ST_READ;
        end
      end
      ST_WRITE_WAIT: begin
        wr_ready_o = 1'b1;
        if (wr_valid_i) begin
          din_d   = wr_data_i;
          state_d = ST_WRITE;
        end
      end
      ST_WRITE: begin
        mem_o.en = 1'b1;
        mem_o.we = 1'b1;
        addr_d   = addr_q + 1'b1;   // Next word
        beats_d  = beats_q - 1'b1;
        state_d  = (beats_q == BEATS_WIDTH'(1)) ? ST_IDLE : ST_WRITE_WAIT;
      end
      ST_READ: begin
        mem_o.en = 1'b1;
        addr_d   = addr_q + 1'b1;
        beats_d  = beats_q - 1'b1;
        state_d  = ST_READ_CAPTURE;
      end
      ST_READ_CAPTURE: begin
        rdata_d = mem_rdata_i;      // RAM output one cycle after en
        state_d = ST_READ_WAIT;
      end
      ST_READ_WAIT: begin
        rd_valid_o = 1'b1;
        if (rd_ready_i) begin
          state_d = (beats_q == '0) ? ST_IDLE : ST_READ;  // Next beat only after take
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

endmodule

`default_nettype wire

// ==== mam_req_fifo.sv ====
`default_nettype none

module mam_req_fifo
  import mam_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     push_i,
  input  mam_req_t req_i,
  output logic     full_o,
  input  logic     pop_i,
  output mam_req_t req_o,
  output logic     valid_o
);

  mam_req_t               mem_q [FIFO_DEPTH];  // Entry storage
  logic [FIFO_PTR_W-1:0]  wr_ptr_q;
  logic [FIFO_PTR_W-1:0]  rd_ptr_q;
  logic [FIFO_CNT_W-1:0]  count_q;             // Fill level
  logic                   do_push;
  logic                   do_pop;

  assign full_o  = (count_q == FIFO_CNT_W'(FIFO_DEPTH));
  assign valid_o = (count_q != '0);
  assign req_o   = mem_q[rd_ptr_q];            // Head entry

  assign do_push = push_i & ~full_o;           // Push on full is dropped
  assign do_pop  = pop_i & valid_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;  // Wraps at depth
      if (do_pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;                               // Both or neither
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= req_i;
  end

endmodule

`default_nettype wire

// ==== mam_cmd_decoder.sv ====
`default_nettype none

module mam_cmd_decoder
  import mam_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  dbg_valid_i,
  input  mam_word_u             dbg_word_i,
  output logic                  dbg_ready_o,
  output logic                  req_valid_o,
  output mam_req_t              req_o,
  input  logic                  req_ready_i,
  output logic                  wr_valid_o,
  output logic [DATA_WIDTH-1:0] wr_data_o,
  input  logic                  wr_ready_i
);

  typedef enum logic [2:0] {
    PH_HDR,      // Waiting for header word
    PH_ADDR_HI,  // Upper address half
    PH_ADDR_LO,  // Lower address half
    PH_PUSH,     // Request offered to queue
    PH_DATA      // Forwarding write data
  } phase_e;

  phase_e                 phase_q;
  logic                   run_q;      // Low for the first cycle after reset
  mam_req_t               req_q;
  logic [BEATS_WIDTH-1:0] cnt_q;      // Data words still to accept
  logic                   wr_valid_q;
  logic [DATA_WIDTH-1:0]  wr_data_q;
  logic                   dbg_take;
  logic                   wr_take;
  logic [BEATS_WIDTH-1:0] hdr_beats;

  assign dbg_take = dbg_valid_i & dbg_ready_o;
  assign wr_take  = wr_valid_q & wr_ready_i;

  // Single access or zero length means one beat
  assign hdr_beats = (!dbg_word_i.hdr.burst || dbg_word_i.hdr.beats == '0) ?
                     BEATS_WIDTH'(1) : dbg_word_i.hdr.beats;

  always_comb begin
    case (phase_q)
      PH_HDR, PH_ADDR_HI, PH_ADDR_LO: dbg_ready_o = run_q;
      PH_DATA: dbg_ready_o = (cnt_q != '0) && (!wr_valid_q || wr_ready_i);  // Slot free soon
      default: dbg_ready_o = 1'b0;                                          // Stall while pushing
    endcase
  end

  assign req_valid_o = (phase_q == PH_PUSH);
  assign req_o       = req_q;
  assign wr_valid_o  = wr_valid_q;
  assign wr_data_o   = wr_data_q;

  ////////////////////////////////////////////////////////////////////////////
  // Phase control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      phase_q    <= PH_HDR;
      run_q      <= 1'b0;
      wr_valid_q <= 1'b0;
      cnt_q      <= '0;
    end else begin
      run_q <= 1'b1;
      case (phase_q)
        PH_HDR:     if (dbg_take) phase_q <= PH_ADDR_HI;
        PH_ADDR_HI: if (dbg_take) phase_q <= PH_ADDR_LO;
        PH_ADDR_LO: if (dbg_take) phase_q <= PH_PUSH;
        PH_PUSH: begin
          if (req_ready_i) begin                      // Queue took it
            cnt_q   <= req_q.beats;
            phase_q <= req_q.we ? PH_DATA : PH_HDR;   // Reads carry no data
          end
        end
        PH_DATA: begin
          if (dbg_take) begin
            wr_valid_q <= 1'b1;                       // Refill, maybe same cycle as take
            cnt_q      <= cnt_q - 1'b1;
          end else if (wr_take) begin
            wr_valid_q <= 1'b0;
          end
          if (cnt_q == '0 && wr_take) phase_q <= PH_HDR;  // Last word handed over
        end
        default: phase_q <= PH_HDR;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Request and data capture
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (dbg_take) begin
      case (phase_q)
        PH_HDR: begin
          req_q.we    <= dbg_word_i.hdr.we;
          req_q.burst <= dbg_word_i.hdr.burst;
          req_q.strb  <= dbg_word_i.hdr.burst ? '1 : dbg_word_i.hdr.strb;  // Bursts write whole words
          req_q.beats <= hdr_beats;
        end
        PH_ADDR_HI: req_q.addr[ADDR_WIDTH-1:DATA_WIDTH] <= dbg_word_i.raw;
        PH_ADDR_LO: req_q.addr[DATA_WIDTH-1:0]          <= dbg_word_i.raw;
        PH_DATA:    wr_data_q                           <= dbg_word_i.raw;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== mem_pkg.sv ====
`default_nettype none

package mem_pkg;

  import mam_pkg::*;

  localparam int MEM_AW    = 8;             // Word address bits seen by the RAM
  localparam int MEM_DEPTH = 1 << MEM_AW;   // 256 words

  // One RAM access, valid while en is high
  typedef struct packed {
    logic                  en;
    logic                  we;
    logic [MEM_AW-1:0]     addr;
    logic [DATA_WIDTH-1:0] wdata;
    logic [STRB_WIDTH-1:0] be;   // Byte enables for writes
  } mem_req_t;

endpackage

`default_nettype wire

// ==== mam_pkg.sv ====
`default_nettype none

package mam_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Word and request geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int DATA_WIDTH  = 16;                         // Debug word and memory word
  localparam int STRB_WIDTH  = DATA_WIDTH / 8;             // Byte strobes per word
  localparam int ADDR_WIDTH  = 32;                         // Word address, not byte address
  localparam int BEATS_WIDTH = 12;                         // Burst length field
  localparam int FIFO_DEPTH  = 4;                          // Request queue entries
  localparam int FIFO_PTR_W  = $clog2(FIFO_DEPTH);         // Queue pointer bits
  localparam int FIFO_CNT_W  = $clog2(FIFO_DEPTH + 1);     // Queue fill level bits

  ////////////////////////////////////////////////////////////////////////////
  // Command words
  ////////////////////////////////////////////////////////////////////////////

  // First word of every command
  typedef struct packed {
    logic                   we;     // 1 write, 0 read
    logic                   burst;  // Incrementing burst
    logic [STRB_WIDTH-1:0]  strb;   // Byte strobe, single access only
    logic [BEATS_WIDTH-1:0] beats;  // Burst length, 0 taken as 1
  } mam_hdr_t;

  // Same debug word, header or plain data depending on phase
  typedef union packed {
    mam_hdr_t              hdr;
    logic [DATA_WIDTH-1:0] raw;
  } mam_word_u;

  // Decoded request as queued for the block RAM interface
  typedef struct packed {
    logic                   we;
    logic                   burst;
    logic [STRB_WIDTH-1:0]  strb;   // All ones for bursts
    logic [BEATS_WIDTH-1:0] beats;  // Always at least 1
    logic [ADDR_WIDTH-1:0]  addr;   // Start word address
  } mam_req_t;

endpackage

`default_nettype wire
